/* Makefile */
# Verilator build and run for the flip-candidate stage

TOP = flip_unit_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, pass if the log shows the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* include/sat_defines.svh */
// sizing macros for the 3-SAT flip-candidate stage
// literals per clause, variable address, flip index and break-count widths

`ifndef SAT_DEFINES_SVH
`define SAT_DEFINES_SVH

// literals per clause, equal to the number of candidate flips
`define SAT_NSAT 3

// variable address width, one literal is this plus a negated bit
`define SAT_VAR_WIDTH 11

// enough bits to count 0 .. SAT_NSAT-1
`define SAT_IDX_WIDTH 2

// break count as returned by the external table
`define SAT_BREAK_WIDTH 8

`endif

/* rtl/clause_scanner.sv */
// clause_scanner
// latches a broken clause and walks its literals, one flip candidate per cycle
// also presents the candidate's variable address to the break-count table

`timescale 1ns/1ps
`default_nettype none

`include "sat_defines.svh"

module clause_scanner
    import sat_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         clause_valid_i,  // one-cycle strobe
    input  wire clause_t                clause_i,
    output flip_cand_t                  cand_o,          // current candidate flip
    output logic                        cand_valid_o,
    output logic                        cand_last_o,     // candidate index is the last one
    output logic [`SAT_VAR_WIDTH-1:0]   var_addr_o,      // table lookup address
    output logic                        busy_o
);

    localparam logic [`SAT_IDX_WIDTH-1:0] LAST_IDX = `SAT_IDX_WIDTH'(`SAT_NSAT - 1);

    scan_state_t                 state_q;
    logic [`SAT_IDX_WIDTH-1:0]   idx_q;     // literal being flipped
    clause_t                     clause_q;  // latched clause
    literal_t                    sel_lit;   // literal at idx_q
    logic                        accept;    // strobe taken this cycle

    assign busy_o       = (state_q == SCAN_RUN);
    assign cand_valid_o = busy_o;                           // one candidate per busy cycle
    assign cand_last_o  = busy_o && (idx_q == LAST_IDX);

    // new clause allowed when idle or on the last candidate, so clauses can run back to back
    assign accept = clause_valid_i && (!busy_o || cand_last_o);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= SCAN_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                SCAN_IDLE: begin
                    if (accept) begin
                        state_q <= SCAN_RUN;  // first candidate next cycle
                        idx_q   <= '0;
                    end
                end
                SCAN_RUN: begin
                    if (accept) begin
                        idx_q   <= '0;        // reload straight from the last cycle
                    end else if (cand_last_o) begin
                        state_q <= SCAN_IDLE;
                        idx_q   <= '0;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= SCAN_IDLE;
                    idx_q   <= '0;
                end
            endcase
        end
    end

    // clause payload only moves on an accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            clause_q <= clause_i;
        end
    end

    assign sel_lit = clause_q[idx_q];

    // candidate: indexed literal with inverted polarity, then the other two in order
    always_comb begin
        cand_o.index            = idx_q;
        cand_o.flipped.negated  = ~sel_lit.negated;        // the actual flip
        cand_o.flipped.var_addr = sel_lit.var_addr;
        for (int r = 0; r < `SAT_NSAT - 1; r++) begin
            if (r < int'(idx_q)) begin
                cand_o.rest[r] = clause_q[r];               // literals before the flip
            end else begin
                cand_o.rest[r] = clause_q[r + 1];           // skip over the flipped slot
            end
        end
    end

    assign var_addr_o = cand_o.flipped.var_addr;            // table answers in the same cycle

endmodule

`default_nettype wire

/* rtl/flip_selector.sv */
// flip_selector
// keeps the lowest break count seen for the current clause and its index
// reports the winner in the last candidate cycle, lower index wins on ties

`timescale 1ns/1ps
`default_nettype none

`include "sat_defines.svh"

module flip_selector (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           cand_valid_i,   // candidate present this cycle
    input  wire                           cand_last_i,    // last candidate of the clause
    input  wire [`SAT_IDX_WIDTH-1:0]      cand_index_i,
    input  wire [`SAT_BREAK_WIDTH-1:0]    break_count_i,  // table answer for this candidate
    output logic                          sel_valid_o,    // pulse, winner is final
    output logic [`SAT_IDX_WIDTH-1:0]     sel_index_o,
    output logic [`SAT_BREAK_WIDTH-1:0]   sel_break_o
);

    logic [`SAT_BREAK_WIDTH-1:0]  min_break_q;  // running minimum
    logic [`SAT_IDX_WIDTH-1:0]    min_idx_q;    // index that produced it
    logic                         first_cand;   // index 0 restarts the search
    logic                         take_cur;     // current candidate beats the held one
    logic [`SAT_BREAK_WIDTH-1:0]  best_break;
    logic [`SAT_IDX_WIDTH-1:0]    best_idx;

    assign first_cand = (cand_index_i == '0);

    // strict less-than keeps the earlier index on a tie
    assign take_cur = first_cand || (break_count_i < min_break_q);

    assign best_break = take_cur ? break_count_i : min_break_q;
    assign best_idx   = take_cur ? cand_index_i  : min_idx_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            min_break_q <= '1;
            min_idx_q   <= '0;
        end else if (cand_valid_i) begin
            min_break_q <= best_break;   // fold this candidate in
            min_idx_q   <= best_idx;
        end
    end

    // combinational result over stored minimum and live candidate
    assign sel_valid_o = cand_valid_i && cand_last_i;
    assign sel_index_o = best_idx;
    assign sel_break_o = best_break;

endmodule

`default_nettype wire

/* rtl/flip_unit_top.sv */
// flip_unit_top
// flip-candidate stage of a local-search 3-SAT solver
// scanner -> selector -> temporal buffer, with the break-count table outside

`timescale 1ns/1ps
`default_nettype none

`include "sat_defines.svh"

module flip_unit_top
    import sat_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           clause_valid_i,  // broken clause strobe
    input  wire clause_t                  clause_i,
    input  wire [`SAT_BREAK_WIDTH-1:0]    break_count_i,   // table answer for var_addr_o
    output logic [`SAT_VAR_WIDTH-1:0]     var_addr_o,
    output logic                          cand_valid_o,
    output logic                          busy_o,
    output logic                          flip_valid_o,
    output flip_result_t                  flip_o
);

    flip_cand_t                   cand;        // current candidate
    logic                         cand_last;
    logic                         sel_valid;
    logic [`SAT_IDX_WIDTH-1:0]    sel_index;
    logic [`SAT_BREAK_WIDTH-1:0]  sel_break;

    clause_scanner u_scanner (
        .clk            (clk),
        .reset          (reset),
        .clause_valid_i (clause_valid_i),
        .clause_i       (clause_i),
        .cand_o         (cand),
        .cand_valid_o   (cand_valid_o),
        .cand_last_o    (cand_last),
        .var_addr_o     (var_addr_o),
        .busy_o         (busy_o)
    );

    flip_selector u_selector (
        .clk            (clk),
        .reset          (reset),
        .cand_valid_i   (cand_valid_o),
        .cand_last_i    (cand_last),
        .cand_index_i   (cand.index),
        .break_count_i  (break_count_i),
        .sel_valid_o    (sel_valid),
        .sel_index_o    (sel_index),
        .sel_break_o    (sel_break)
    );

    temporal_buffer u_buffer (
        .clk            (clk),
        .reset          (reset),
        .cand_valid_i   (cand_valid_o),
        .cand_i         (cand),
        .sel_valid_i    (sel_valid),
        .sel_index_i    (sel_index),
        .sel_break_i    (sel_break),
        .flip_valid_o   (flip_valid_o),
        .flip_o         (flip_o)
    );

endmodule

`default_nettype wire

/* rtl/sat_pkg.sv */
// shared types for the flip-candidate stage
// literal, clause, flip candidate, flip result and scanner state

`default_nettype none

`include "sat_defines.svh"

package sat_pkg;

    typedef struct packed {
        logic                          negated;   // polarity, 1 = negated literal
        logic [`SAT_VAR_WIDTH-1:0]     var_addr;  // variable address
    } literal_t;                                  // 12 bits

    typedef literal_t [`SAT_NSAT-1:0] clause_t;   // element 0 in the low bits

    typedef struct packed {
        logic [`SAT_IDX_WIDTH-1:0]     index;     // which literal is flipped
        literal_t                      flipped;   // chosen literal, polarity inverted
        literal_t [`SAT_NSAT-2:0]      rest;      // remaining literals, original order
    } flip_cand_t;                                // 38 bits

    typedef struct packed {
        clause_t                       clause;      // rewritten clause, flip in slot 0
        logic [`SAT_IDX_WIDTH-1:0]     index;       // winning flip index
        logic [`SAT_BREAK_WIDTH-1:0]   break_count; // its break count
    } flip_result_t;                                // 46 bits

    typedef enum logic {
        SCAN_IDLE,                                // waiting for a clause
        SCAN_RUN                                  // stepping through the literals
    } scan_state_t;

endpackage

`default_nettype wire

/* rtl/temporal_buffer.sv */
// temporal_buffer
// one rewritten clause per flip index, written as candidates go by
// registers the clause of the selected flip along with its index and break count
// the last row is bypassed from the live candidate

`timescale 1ns/1ps
`default_nettype none

`include "sat_defines.svh"

module temporal_buffer
    import sat_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           cand_valid_i,  // write strobe for the candidate row
    input  wire flip_cand_t               cand_i,
    input  wire                           sel_valid_i,   // winner is known this cycle
    input  wire [`SAT_IDX_WIDTH-1:0]      sel_index_i,
    input  wire [`SAT_BREAK_WIDTH-1:0]    sel_break_i,
    output logic                          flip_valid_o,  // one-cycle pulse
    output flip_result_t                  flip_o         // held until the next pulse
);

    localparam logic [`SAT_IDX_WIDTH-1:0] LAST_IDX = `SAT_IDX_WIDTH'(`SAT_NSAT - 1);

    clause_t  rows_q [`SAT_NSAT];  // rows_q[i] = clause rewritten for flip i
    clause_t  cand_clause;         // live candidate as a clause
    clause_t  sel_clause;          // row picked for output

    // flipped literal goes in slot 0, the rest follow
    always_comb begin
        cand_clause[0] = cand_i.flipped;
        for (int r = 1; r < `SAT_NSAT; r++) begin
            cand_clause[r] = cand_i.rest[r - 1];
        end
    end

    // row write in the candidate cycle
    always_ff @(posedge clk) begin
        if (cand_valid_i) begin
            rows_q[cand_i.index] <= cand_clause;
        end
    end

    // last row is still being written now, so read it off the candidate
    assign sel_clause = (sel_index_i == LAST_IDX) ? cand_clause : rows_q[sel_index_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            flip_valid_o <= 1'b0;
        end else begin
            flip_valid_o <= sel_valid_i;      // one cycle after selection
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid_i) begin
            flip_o.clause      <= sel_clause;
            flip_o.index       <= sel_index_i;
            flip_o.break_count <= sel_break_i;
        end
    end

endmodule

`default_nettype wire

/* sim/flip_unit_props.sv */
// concurrent assertions for flip_unit_top
// latency, busy window, strobe pulses and quiet outputs around reset

`timescale 1ns/1ps
`default_nettype none

module flip_unit_props (
    input wire clk,
    input wire reset,
    input wire clause_valid_i,
    input wire cand_last_i,      // scanner is on the last literal
    input wire busy_o,
    input wire cand_valid_o,
    input wire flip_valid_o
);

    logic accept;                // strobe taken when idle or on the last candidate
    int   failures = 0;          // failed assertions so far

    assign accept = clause_valid_i && (!busy_o || cand_last_i);

    a_latency: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##4 flip_valid_o) else begin
            $error("flip_valid_o not 4 cycles after accept");
            failures++;
        end

    a_busy_run: assert property (@(posedge clk) disable iff (reset)
        accept |=> busy_o ##1 busy_o ##1 (busy_o && cand_last_i)) else begin
            $error("busy_o window shorter than 3 cycles");
            failures++;
        end

    // busy drops after the last candidate unless a new clause came in
    a_busy_end: assert property (@(posedge clk) disable iff (reset)
        cand_last_i |=> (busy_o == $past(accept))) else begin
            $error("busy_o longer than 3 cycles");
            failures++;
        end

    // one candidate per literal after each accepted clause
    a_cand_run: assert property (@(posedge clk) disable iff (reset)
        accept |=> cand_valid_o [*3]) else begin
            $error("cand_valid_o not high for the three candidate cycles");
            failures++;
        end

    a_flip_pulse: assert property (@(posedge clk) disable iff (reset)
        flip_valid_o |=> !flip_valid_o) else begin
            $error("flip_valid_o held for two cycles");
            failures++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> (!busy_o && !cand_valid_o && !flip_valid_o)) else begin
            $error("control outputs active during or right after reset");
            failures++;
        end

endmodule

bind flip_unit_top flip_unit_props u_props (
    .clk            (clk),
    .reset          (reset),
    .clause_valid_i (clause_valid_i),
    .cand_last_i    (cand_last),
    .busy_o         (busy_o),
    .cand_valid_o   (cand_valid_o),
    .flip_valid_o   (flip_valid_o)
);

`default_nettype wire

/* sim/flip_unit_tb.sv */
// testbench for flip_unit_top
// clock, reset, random and forced-last-index clauses, break-count table model
// expected-result and candidate-address queues, immediate checks, watchdog, closing summary

`timescale 1ns/1ps
`default_nettype none

`include "sat_defines.svh"

module flip_unit_tb
    import sat_pkg::*;
();

    localparam int CLK_PERIOD  = 100;                        // ns
    localparam int NUM_CLAUSES = 200;
    localparam int LATENCY     = 4;                          // accept edge to flip_valid_o
    localparam int MAX_GAP     = 3;                          // gap draw is 0 .. MAX_GAP
    localparam int TIMEOUT_CYCLES = NUM_CLAUSES * (LATENCY + MAX_GAP) + 100;
    localparam logic [`SAT_IDX_WIDTH-1:0] LAST_IDX = `SAT_IDX_WIDTH'(`SAT_NSAT - 1);

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          clause_valid_i;
    clause_t                       clause_i;
    logic [`SAT_BREAK_WIDTH-1:0]   break_count;              // table answer
    logic [`SAT_VAR_WIDTH-1:0]     var_addr;
    logic                          cand_valid;
    logic                          busy;
    logic                          flip_valid;
    flip_result_t                  flip;

    integer        seed = 43994;
    int            errors = 0;
    int            sent = 0;
    int            checked = 0;
    int            last_wins = 0;                            // results taken from the bypass row
    int            b2b = 0;                                  // clauses sent in the last candidate cycle
    flip_result_t  exp_q [$];                                // expected results, oldest first
    logic [`SAT_VAR_WIDTH-1:0] addr_q [$];                   // expected lookup addresses, in order

    always #(CLK_PERIOD / 2) clk = ~clk;

    // break-count table, small range on purpose so ties are common
    function automatic logic [`SAT_BREAK_WIDTH-1:0] table_lookup(
        input logic [`SAT_VAR_WIDTH-1:0] addr);
        int h;
        h = int'(addr) * 37 + int'(addr >> 5);
        return `SAT_BREAK_WIDTH'(h % 16);
    endfunction

    assign break_count = table_lookup(var_addr);             // answers in the same cycle

    flip_unit_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .clause_valid_i (clause_valid_i),
        .clause_i       (clause_i),
        .break_count_i  (break_count),
        .var_addr_o     (var_addr),
        .cand_valid_o   (cand_valid),
        .busy_o         (busy),
        .flip_valid_o   (flip_valid),
        .flip_o         (flip)
    );

    task automatic make_random_clause(output clause_t c);
        int r;
        for (int i = 0; i < `SAT_NSAT; i++) begin
            r = $random(seed);
            c[i] = r[11:0];                                  // bit 11 polarity, rest address
        end
    endtask

    // only the last literal gets count 0, so index 2 has to win
    task automatic make_last_wins_clause(output clause_t c);
        int r;
        for (int i = 0; i < `SAT_NSAT; i++) begin
            do begin
                r = $random(seed);
                c[i] = r[11:0];
            end while ((table_lookup(c[i].var_addr) == 0) != (i == `SAT_NSAT - 1));
        end
    endtask

    // lowest count wins, first index on ties; flipped literal first, others in order
    task automatic queue_expected(input clause_t c);
        flip_result_t res;
        int best;
        int k;
        best = 0;
        for (int i = 1; i < `SAT_NSAT; i++) begin
            if (table_lookup(c[i].var_addr) < table_lookup(c[best].var_addr)) begin
                best = i;
            end
        end
        res.index          = `SAT_IDX_WIDTH'(best);
        res.break_count    = table_lookup(c[best].var_addr);
        res.clause[0]      = c[best];
        res.clause[0].negated = ~c[best].negated;            // polarity flip
        k = 1;
        for (int i = 0; i < `SAT_NSAT; i++) begin
            if (i != best) begin
                res.clause[k] = c[i];
                k++;
            end
        end
        exp_q.push_back(res);
    endtask

    // strobe for one cycle, returns just after the accepting edge
    task automatic send_clause(input clause_t c);
        clause_valid_i = 1'b1;
        clause_i       = c;
        @(posedge clk);
        #1;
        clause_valid_i = 1'b0;
        for (int i = 0; i < `SAT_NSAT; i++) begin
            addr_q.push_back(c[i].var_addr);                 // candidate i looks up literal i
        end
        sent++;
    endtask

    // one candidate per cycle while lookups are outstanding, none otherwise
    always @(negedge clk) begin
        logic [`SAT_VAR_WIDTH-1:0] exp_addr;
        if (!reset) begin
            assert (cand_valid == (addr_q.size() != 0)) else begin
                $display("CHECK FAILED at %0t: cand_valid_o %b, expected %b",
                         $time, cand_valid, addr_q.size() != 0);
                errors++;
            end
            if (cand_valid && addr_q.size() != 0) begin
                exp_addr = addr_q.pop_front();
                assert (var_addr == exp_addr) else begin
                    $display("CHECK FAILED at %0t: var_addr_o %h, expected %h",
                             $time, var_addr, exp_addr);
                    errors++;
                end
            end
        end
    end

    // results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        flip_result_t res;
        if (!reset && flip_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: flip_valid_o pulsed with no clause outstanding", $time);
                errors++;
            end else begin
                res = exp_q.pop_front();
                checked++;
                if (res.index == LAST_IDX) last_wins++;
                assert (flip.clause == res.clause) else begin
                    $display("CHECK FAILED at %0t: clause %h, expected %h",
                             $time, flip.clause, res.clause);
                    errors++;
                end
                assert (flip.index == res.index) else begin
                    $display("CHECK FAILED at %0t: index %0d, expected %0d",
                             $time, flip.index, res.index);
                    errors++;
                end
                assert (flip.break_count == res.break_count) else begin
                    $display("CHECK FAILED at %0t: break count %0d, expected %0d",
                             $time, flip.break_count, res.break_count);
                    errors++;
                end
            end
        end
    end

    initial begin
        clause_t cl;
        int      gap;
        reset          = 1'b1;
        clause_valid_i = 1'b0;
        clause_i       = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_CLAUSES; n++) begin
            if (n % 5 == 4) begin
                make_last_wins_clause(cl);                   // bypass path
            end else begin
                make_random_clause(cl);
            end
            queue_expected(cl);
            send_clause(cl);
            gap = $random(seed) & MAX_GAP;
            if (gap < 2) begin
                repeat (2) @(posedge clk);                   // land in the last candidate cycle
                #1;
                if (n < NUM_CLAUSES - 1) b2b++;
            end else begin
                while (busy) begin
                    @(posedge clk);
                    #1;
                end
                repeat (gap - 2) begin                       // extra idle cycles
                    @(posedge clk);
                    #1;
                end
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (checked != sent) begin
            $display("ERROR: %0d clauses sent but %0d results seen", sent, checked);
            errors++;
        end
        if (last_wins == 0 || b2b == 0) begin
            $display("ERROR: stimulus missed the last-index bypass or back-to-back clauses");
            errors++;
        end
        if (u_dut.u_props.failures != 0) begin
            $display("ERROR: %0d timing or reset assertions failed",
                     u_dut.u_props.failures);
            errors += u_dut.u_props.failures;
        end
        $display("clauses %0d  results %0d  last-index wins %0d  back-to-back %0d  errors %0d",
                 sent, checked, last_wins, b2b, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, bound from the worst per-clause spacing
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the DUT stopped answering",
                 TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/sat_pkg.sv
rtl/clause_scanner.sv
rtl/flip_selector.sv
rtl/temporal_buffer.sv
rtl/flip_unit_top.sv
sim/flip_unit_props.sv
sim/flip_unit_tb.sv
